// ==== vlog.f ====
logic/AddressTypes.sv
logic/PredictorTypes.sv
logic/PredictorRam.sv
logic/BimodalPht.sv
logic/TargetBuffer.sv
logic/FetchPredictor.sv
logic/BranchPredictorTop.sv
test/PredictorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= PredictorTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/PredictorTb.sv ====
/*
 * Testbench for the fetch-stage branch predictor.
 * Drives lookups and resolved branches from a fixed-seed LFSR and
 * checks every prediction against a reference model of both tables.
 */
module PredictorTb;
    timeunit 1ns;
    timeprecision 1ps;

    import AddressTypes::*;
    import PredictorTypes::*;

    localparam int fetchWidth = 2;
    localparam int issueWidth = 2;
    localparam int phtEntryNum = 256;
    localparam int btbEntryNum = 16;
    localparam int queueSize = 4;
    localparam int phtIndexWidth = $clog2(phtEntryNum);
    localparam int btbIndexWidth = $clog2(btbEntryNum);

    localparam int initIters = 16;
    localparam int trainIters = 40;
    localparam int dualIters = 20;
    localparam int targetIters = 16;
    localparam int mixedIters = 60;
    localparam int totalIters = initIters + trainIters + dualIters + targetIters + mixedIters;
    // Upper bound on the cycles one iteration of any test takes.
    localparam int cyclesPerIter = 32;
    localparam longint clockPeriod = 40;
    localparam longint watchdogNs =
        (3 + phtEntryNum + totalIters * cyclesPerIter) * clockPeriod * 2;

    logic clock = 1'b0;
    logic reset;
    PcAddr fetchPc;
    logic resValid [issueWidth];
    PcAddr resPc [issueWidth];
    logic resTaken [issueWidth];
    PcAddr resTarget [issueWidth];
    PhtCounter resPrevCounter [issueWidth];
    logic predTaken [fetchWidth];
    PcAddr predNextPc;
    PhtCounter predCounter [fetchWidth];
    logic initBusy;

    logic [31:0] lfsrState;
    int errorCount;
    int checkCount;
    int testsRun;
    int testsFailed;

    // Reference model of both tables.
    PhtCounter modelPht [phtEntryNum];
    logic modelBtbValid [btbEntryNum];
    BtbTag modelBtbTag [btbEntryNum];
    PcAddr modelBtbTarget [btbEntryNum];

    // Results staged for the next update burst.
    logic reqValid [issueWidth];
    PcAddr reqPc [issueWidth];
    logic reqTaken [issueWidth];
    PcAddr reqTarget [issueWidth];
    PhtCounter reqPrev [issueWidth];

    BranchPredictorTop #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .phtEntryNum(phtEntryNum),
        .btbEntryNum(btbEntryNum),
        .queueSize(queueSize)
    ) u_BranchPredictorTop (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .resValid(resValid),
        .resPc(resPc),
        .resTaken(resTaken),
        .resTarget(resTarget),
        .resPrevCounter(resPrevCounter),
        .predTaken(predTaken),
        .predNextPc(predNextPc),
        .predCounter(predCounter),
        .initBusy(initBusy)
    );

    always #(clockPeriod / 2) clock = ~clock;

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    function automatic PcAddr randomPc();
        return randomBits(30) << 2;
    endfunction

    // Four tags share every BTB index so entries get replaced often.
    function automatic PcAddr aliasPc();
        return 32'h0001_0000 | (randomBits(2) << 6) | (randomBits(4) << 2);
    endfunction

    function automatic logic [phtIndexWidth-1:0] phtIndexOf(PcAddr pc);
        return pc[2 +: phtIndexWidth];
    endfunction

    function automatic logic [btbIndexWidth-1:0] btbIndexOf(PcAddr pc);
        return pc[2 +: btbIndexWidth];
    endfunction

    function automatic BtbTag btbTagOf(PcAddr pc);
        return pc[2 + btbIndexWidth +: btbTagBitWidth];
    endfunction

    function automatic logic modelHit(PcAddr pc);
        return modelBtbValid[btbIndexOf(pc)] && (modelBtbTag[btbIndexOf(pc)] == btbTagOf(pc));
    endfunction

    function automatic PhtCounter satCounter(PhtCounter prev, logic taken);
        int value;
        value = int'(prev) + (taken ? 1 : -1);
        if (value > int'(counterMax)) begin
            value = int'(counterMax);
        end
        if (value < 0) begin
            value = 0;
        end
        return PhtCounter'(value);
    endfunction

    task automatic checkCounter(string name, PhtCounter expected, PhtCounter actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkPc(string name, PcAddr expected, PcAddr actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic checkTaken(string name, logic expected, logic actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    // Drives one lookup PC and checks the outputs in the middle of the following cycle.
    task automatic lookupAndCheck(string testName, PcAddr pc);
        PcAddr slotPc;
        PhtCounter expCounter;
        logic expTaken;
        logic takenFound;
        PcAddr expNext;
        @(posedge clock);
        fetchPc <= pc;
        @(posedge clock);
        @(negedge clock);
        takenFound = 1'b0;
        expNext = pc + PcAddr'(fetchWidth * insnByteWidth);
        for (int slot = 0; slot < fetchWidth; slot++) begin
            slotPc = pc + PcAddr'(slot * insnByteWidth);
            expCounter = modelPht[phtIndexOf(slotPc)];
            expTaken = !takenFound && modelHit(slotPc) && expCounter[counterBitWidth-1];
            checkCounter($sformatf("%s predCounter[%0d] pc 0x%08h", testName, slot, pc),
                         expCounter, predCounter[slot]);
            checkTaken($sformatf("%s predTaken[%0d] pc 0x%08h", testName, slot, pc),
                       expTaken, predTaken[slot]);
            if (expTaken) begin
                takenFound = 1'b1;
                expNext = modelBtbTarget[btbIndexOf(slotPc)];
            end
        end
        checkPc($sformatf("%s predNextPc pc 0x%08h", testName, pc), expNext, predNextPc);
    endtask

    task automatic clearRequests();
        for (int lane = 0; lane < issueWidth; lane++) begin
            reqValid[lane] = 1'b0;
            reqPc[lane] = '0;
            reqTaken[lane] = 1'b0;
            reqTarget[lane] = '0;
            reqPrev[lane] = '0;
        end
    endtask

    task automatic setRequest(int lane, PcAddr pc, logic taken, PcAddr target,
                              PhtCounter prev);
        reqValid[lane] = 1'b1;
        reqPc[lane] = pc;
        reqTaken[lane] = taken;
        reqTarget[lane] = target;
        reqPrev[lane] = prev;
    endtask

    // Drives one burst of results, updates the model, then waits out the queue.
    task automatic issueResults();
        logic installed;
        @(posedge clock);
        for (int lane = 0; lane < issueWidth; lane++) begin
            resValid[lane] <= reqValid[lane];
            resPc[lane] <= reqPc[lane];
            resTaken[lane] <= reqTaken[lane];
            resTarget[lane] <= reqTarget[lane];
            resPrevCounter[lane] <= reqPrev[lane];
        end
        installed = 1'b0;
        for (int lane = 0; lane < issueWidth; lane++) begin
            if (reqValid[lane]) begin
                modelPht[phtIndexOf(reqPc[lane])] = satCounter(reqPrev[lane], reqTaken[lane]);
                if (reqTaken[lane] && !installed) begin
                    installed = 1'b1;
                    modelBtbValid[btbIndexOf(reqPc[lane])] = 1'b1;
                    modelBtbTag[btbIndexOf(reqPc[lane])] = btbTagOf(reqPc[lane]);
                    modelBtbTarget[btbIndexOf(reqPc[lane])] = reqTarget[lane];
                end
            end
        end
        @(posedge clock);
        for (int lane = 0; lane < issueWidth; lane++) begin
            resValid[lane] <= 1'b0;
        end
        repeat (queueSize) @(posedge clock);
    endtask

    task automatic trainOne(PcAddr pc, logic taken, PcAddr target, PhtCounter prev);
        clearRequests();
        setRequest(0, pc, taken, target, prev);
        issueResults();
    endtask

    task automatic finishTest(string testName, int errorsAtStart);
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("%s: passed", testName);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", testName, errorCount - errorsAtStart);
        end
    endtask

    task automatic waitForInit(output logic done);
        done = 1'b0;
        for (int cycle = 0; cycle < phtEntryNum + 16; cycle++) begin
            @(negedge clock);
            if (!initBusy) begin
                done = 1'b1;
                break;
            end
        end
    endtask

    task automatic runInitTest();
        int errorsAtStart;
        errorsAtStart = errorCount;
        for (int iter = 0; iter < initIters; iter++) begin
            lookupAndCheck("init", randomPc());
        end
        finishTest("init", errorsAtStart);
    endtask

    task automatic runTrainingTest();
        int errorsAtStart;
        PcAddr pc;
        logic taken;
        PcAddr target;
        PhtCounter prev;
        errorsAtStart = errorCount;
        for (int iter = 0; iter < trainIters; iter++) begin
            pc = randomPc();
            taken = 1'(randomBits(1));
            target = randomPc();
            prev = PhtCounter'(randomBits(2));
            trainOne(pc, taken, target, prev);
            lookupAndCheck("training", pc);
        end
        finishTest("training", errorsAtStart);
    endtask

    task automatic runDualLaneTest();
        int errorsAtStart;
        PcAddr pc [issueWidth];
        logic taken;
        PcAddr target;
        PhtCounter prev;
        errorsAtStart = errorCount;
        for (int iter = 0; iter < dualIters; iter++) begin
            pc[0] = randomPc();
            // Second PC lands on a different PHT entry.
            pc[1] = pc[0] + ((randomBits(6) + 32'd1) << 2);
            clearRequests();
            for (int lane = 0; lane < issueWidth; lane++) begin
                taken = 1'(randomBits(1));
                target = randomPc();
                prev = PhtCounter'(randomBits(2));
                setRequest(lane, pc[lane], taken, target, prev);
            end
            issueResults();
            lookupAndCheck("dual lane", pc[0]);
            lookupAndCheck("dual lane", pc[1]);
        end
        finishTest("dual lane", errorsAtStart);
    endtask

    task automatic runTargetTest();
        int errorsAtStart;
        PcAddr pc;
        PcAddr nextSlotPc;
        PcAddr target0;
        PcAddr target1;
        errorsAtStart = errorCount;
        for (int iter = 0; iter < targetIters; iter++) begin
            pc = randomPc();
            nextSlotPc = pc + PcAddr'(insnByteWidth);
            target0 = randomPc();
            target1 = randomPc();
            // Branch in slot 1 only.
            trainOne(nextSlotPc, 1'b1, target1, counterInit);
            lookupAndCheck("target", pc);
            // Slot 0 is taken as well so slot 1 is suppressed.
            trainOne(pc, 1'b1, target0, counterInit);
            lookupAndCheck("target", pc);
            // Slot 0 counter drops below 2.
            trainOne(pc, 1'b0, target0, PhtCounter'(1));
            lookupAndCheck("target", pc);
            trainOne(nextSlotPc, 1'b0, target1, PhtCounter'(1));
            lookupAndCheck("target", pc);
        end
        finishTest("target", errorsAtStart);
    endtask

    task automatic runMixedTest();
        int errorsAtStart;
        PcAddr pc;
        logic taken;
        PcAddr target;
        PhtCounter prev;
        errorsAtStart = errorCount;
        for (int iter = 0; iter < mixedIters; iter++) begin
            if (1'(randomBits(1))) begin
                clearRequests();
                for (int lane = 0; lane < issueWidth; lane++) begin
                    if (1'(randomBits(1))) begin
                        pc = aliasPc();
                        taken = 1'(randomBits(1));
                        target = randomPc();
                        prev = PhtCounter'(randomBits(2));
                        setRequest(lane, pc, taken, target, prev);
                    end
                end
                issueResults();
            end
            lookupAndCheck("mixed", aliasPc());
        end
        finishTest("mixed", errorsAtStart);
    endtask

    initial begin
        logic initDone;
        lfsrState = 32'h2669_445b;
        errorCount = 0;
        checkCount = 0;
        testsRun = 0;
        testsFailed = 0;
        for (int i = 0; i < phtEntryNum; i++) begin
            modelPht[i] = counterInit;
        end
        for (int i = 0; i < btbEntryNum; i++) begin
            modelBtbValid[i] = 1'b0;
            modelBtbTag[i] = '0;
            modelBtbTarget[i] = '0;
        end
        clearRequests();
        reset <= 1'b1;
        fetchPc <= '0;
        for (int lane = 0; lane < issueWidth; lane++) begin
            resValid[lane] <= 1'b0;
            resPc[lane] <= '0;
            resTaken[lane] <= 1'b0;
            resTarget[lane] <= '0;
            resPrevCounter[lane] <= '0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        waitForInit(initDone);
        if (!initDone) begin
            errorCount++;
            testsFailed++;
            $display("initBusy never fell after the reset sweep of %0d entries", phtEntryNum);
        end else begin
            runInitTest();
            runTrainingTest();
            runDualLaneTest();
            runTargetTest();
            runMixedTest();
        end
        $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== logic/BranchPredictorTop.sv ====
/*
 * Fetch-stage branch predictor.
 * Bimodal direction table, branch target buffer and the slot combiner
 * for a two-wide fetch.
 */
module BranchPredictorTop #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int phtEntryNum = 256,
    parameter int btbEntryNum = 16,
    parameter int queueSize = 4
) (
    input  logic clock,
    input  logic reset,
    input  AddressTypes::PcAddr fetchPc,
    input  logic resValid [issueWidth],
    input  AddressTypes::PcAddr resPc [issueWidth],
    input  logic resTaken [issueWidth],
    input  AddressTypes::PcAddr resTarget [issueWidth],
    input  PredictorTypes::PhtCounter resPrevCounter [issueWidth],
    output logic predTaken [fetchWidth],
    output AddressTypes::PcAddr predNextPc,
    output PredictorTypes::PhtCounter predCounter [fetchWidth],
    output logic initBusy
);
    import AddressTypes::*;
    import PredictorTypes::*;

    PhtCounter counterRead [fetchWidth];
    logic btbHit [fetchWidth];
    PcAddr btbTarget [fetchWidth];

    BimodalPht #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .phtEntryNum(phtEntryNum),
        .queueSize(queueSize)
    ) u_BimodalPht (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .resValid(resValid),
        .resPc(resPc),
        .resTaken(resTaken),
        .resPrevCounter(resPrevCounter),
        .counterRead(counterRead),
        .initBusy(initBusy)
    );

    TargetBuffer #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .btbEntryNum(btbEntryNum)
    ) u_TargetBuffer (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .resValid(resValid),
        .resPc(resPc),
        .resTaken(resTaken),
        .resTarget(resTarget),
        .btbHit(btbHit),
        .btbTarget(btbTarget)
    );

    FetchPredictor #(
        .fetchWidth(fetchWidth)
    ) u_FetchPredictor (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .counterRead(counterRead),
        .btbHit(btbHit),
        .btbTarget(btbTarget),
        .initBusy(initBusy),
        .predTaken(predTaken),
        .predNextPc(predNextPc),
        .predCounter(predCounter)
    );

endmodule

// ==== logic/FetchPredictor.sv ====
/*
 * Fetch group predictor.
 * Combines the counter and BTB lookups into per-slot taken flags
 * and the next fetch PC.
 */
module FetchPredictor #(
    parameter int fetchWidth = 2
) (
    input  logic clock,
    input  logic reset,
    input  AddressTypes::PcAddr fetchPc,
    input  PredictorTypes::PhtCounter counterRead [fetchWidth],
    input  logic btbHit [fetchWidth],
    input  AddressTypes::PcAddr btbTarget [fetchWidth],
    input  logic initBusy,
    output logic predTaken [fetchWidth],
    output AddressTypes::PcAddr predNextPc,
    output PredictorTypes::PhtCounter predCounter [fetchWidth]
);
    import AddressTypes::*;
    import PredictorTypes::*;

    // Fetch PC of the group whose table reads are now on the outputs.
    PcAddr alignedPc;

    always_ff @(posedge clock) begin
        if (reset) begin
            alignedPc <= '0;
        end else begin
            alignedPc <= fetchPc;
        end
    end

    always_comb begin
        logic takenFound;
        takenFound = 1'b0;
        predNextPc = slotAddr(alignedPc, fetchWidth);
        for (int slot = 0; slot < fetchWidth; slot++) begin
            predCounter[slot] = counterRead[slot];
            // Nothing after the first taken slot is executed.
            predTaken[slot] = !initBusy && !takenFound && btbHit[slot] &&
                              counterRead[slot][counterBitWidth-1];
            if (predTaken[slot]) begin
                takenFound = 1'b1;
                predNextPc = btbTarget[slot];
            end
        end
    end

endmodule

// ==== logic/TargetBuffer.sv ====
/*
 * Direct-mapped branch target buffer.
 * Looks up one target per fetch slot and installs the target of the
 * lowest resolved taken branch each cycle.
 */
module TargetBuffer #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int btbEntryNum = 16
) (
    input  logic clock,
    input  logic reset,
    input  AddressTypes::PcAddr fetchPc,
    input  logic resValid [issueWidth],
    input  AddressTypes::PcAddr resPc [issueWidth],
    input  logic resTaken [issueWidth],
    input  AddressTypes::PcAddr resTarget [issueWidth],
    output logic btbHit [fetchWidth],
    output AddressTypes::PcAddr btbTarget [fetchWidth]
);
    import AddressTypes::*;
    import PredictorTypes::*;

    localparam int indexWidth = $clog2(btbEntryNum);

    function automatic logic [indexWidth-1:0] toIndex(PcAddr pc);
        return pc[insnAddrBitWidth +: indexWidth];
    endfunction

    function automatic BtbTag toTag(PcAddr pc);
        return pc[insnAddrBitWidth + indexWidth +: btbTagBitWidth];
    endfunction

    logic [indexWidth-1:0] readIndex [fetchWidth];
    BtbEntry readEntry [fetchWidth];
    BtbTag slotTag [fetchWidth];
    logic slotValid [fetchWidth];
    logic [btbEntryNum-1:0] validBits;

    logic writeEnable;
    logic [indexWidth-1:0] writeIndex;
    BtbEntry writeEntry;

    always_comb begin
        for (int slot = 0; slot < fetchWidth; slot++) begin
            readIndex[slot] = toIndex(slotAddr(fetchPc, slot));
        end
    end

    // Tags and valid bits are registered alongside the table read.
    always_ff @(posedge clock) begin
        for (int slot = 0; slot < fetchWidth; slot++) begin
            slotTag[slot] <= toTag(slotAddr(fetchPc, slot));
            slotValid[slot] <= reset ? 1'b0 : validBits[readIndex[slot]];
        end
    end

    // Scanning downward leaves the lowest taken lane selected.
    always_comb begin
        writeEnable = 1'b0;
        writeIndex = '0;
        writeEntry = '0;
        for (int lane = issueWidth - 1; lane >= 0; lane--) begin
            if (resValid[lane] && resTaken[lane]) begin
                writeEnable = 1'b1;
                writeIndex = toIndex(resPc[lane]);
                writeEntry = '{valid: 1'b1, tag: toTag(resPc[lane]),
                               target: toWordAddr(resTarget[lane])};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '0;
        end else if (writeEnable) begin
            validBits[writeIndex] <= 1'b1;
        end
    end

    always_comb begin
        for (int slot = 0; slot < fetchWidth; slot++) begin
            btbHit[slot] = slotValid[slot] && readEntry[slot].valid &&
                           (readEntry[slot].tag == slotTag[slot]);
            btbTarget[slot] = toPcAddr(readEntry[slot].target);
        end
    end

    PredictorRam #(
        .entryType(BtbEntry),
        .entryNum(btbEntryNum),
        .readNum(fetchWidth)
    ) u_BtbRam (
        .clock(clock),
        .writeEnable(writeEnable),
        .writeAddr(writeIndex),
        .writeData(writeEntry),
        .readAddr(readIndex),
        .readData(readEntry)
    );

endmodule

// ==== logic/BimodalPht.sv ====
/*
 * Bimodal pattern history table.
 * Sweeps the table to weakly taken after reset, trains the counters
 * from resolved branches and queues a second result for the single
 * write port.
 */
module BimodalPht #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int phtEntryNum = 256,
    parameter int queueSize = 4
) (
    input  logic clock,
    input  logic reset,
    input  AddressTypes::PcAddr fetchPc,
    input  logic resValid [issueWidth],
    input  AddressTypes::PcAddr resPc [issueWidth],
    input  logic resTaken [issueWidth],
    input  PredictorTypes::PhtCounter resPrevCounter [issueWidth],
    output PredictorTypes::PhtCounter counterRead [fetchWidth],
    output logic initBusy
);
    import AddressTypes::*;
    import PredictorTypes::*;

    localparam int indexWidth = $clog2(phtEntryNum);
    localparam int queuePtrWidth = $clog2(queueSize);

    function automatic logic [indexWidth-1:0] toIndex(PcAddr pc);
        return pc[insnAddrBitWidth +: indexWidth];
    endfunction

    function automatic PhtCounter nextCounter(PhtCounter prev, logic taken);
        if (taken) begin
            return (prev == counterMax) ? counterMax : prev + 1'b1;
        end
        return (prev == '0) ? '0 : prev - 1'b1;
    endfunction

    logic [indexWidth-1:0] readIndex [fetchWidth];
    logic [indexWidth-1:0] updIndex [issueWidth];
    PhtCounter updCounter [issueWidth];
    logic directValid;
    logic pushValid;
    int directLane;
    int pushLane;

    logic [indexWidth-1:0] sweepIndex;

    PhtUpdate queue [queueSize];
    logic [queuePtrWidth-1:0] headPtr;
    logic [queuePtrWidth-1:0] tailPtr;
    logic [queuePtrWidth:0] queueCount;
    logic queueFull;
    logic queueEmpty;
    logic push;
    logic pop;

    logic writeEnable;
    logic [indexWidth-1:0] writeIndex;
    PhtCounter writeCounter;

    always_comb begin
        for (int slot = 0; slot < fetchWidth; slot++) begin
            readIndex[slot] = toIndex(slotAddr(fetchPc, slot));
        end
    end

    // First valid lane takes the write port and the next one goes to the queue.
    always_comb begin
        directValid = 1'b0;
        pushValid = 1'b0;
        directLane = 0;
        pushLane = 0;
        for (int lane = 0; lane < issueWidth; lane++) begin
            updIndex[lane] = toIndex(resPc[lane]);
            updCounter[lane] = nextCounter(resPrevCounter[lane], resTaken[lane]);
            if (resValid[lane] && !initBusy) begin
                if (!directValid) begin
                    directValid = 1'b1;
                    directLane = lane;
                end else if (!pushValid) begin
                    pushValid = 1'b1;
                    pushLane = lane;
                end
            end
        end
    end

    assign queueFull = (queueCount == (queuePtrWidth + 1)'(queueSize));
    assign queueEmpty = (queueCount == '0);
    // A push into a full queue is lost.
    assign push = pushValid && !queueFull;
    assign pop = !queueEmpty && !directValid && !initBusy;

    always_comb begin
        writeEnable = 1'b1;
        writeIndex = sweepIndex;
        writeCounter = counterInit;
        if (initBusy) begin
            writeIndex = sweepIndex;
        end else if (directValid) begin
            writeIndex = updIndex[directLane];
            writeCounter = updCounter[directLane];
        end else if (pop) begin
            writeIndex = queue[headPtr].index;
            writeCounter = queue[headPtr].counter;
        end else begin
            writeEnable = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sweepIndex <= '0;
            initBusy <= 1'b1;
        end else if (initBusy) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == indexWidth'(phtEntryNum - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            queueCount <= '0;
        end else begin
            if (push) begin
                tailPtr <= (tailPtr == queuePtrWidth'(queueSize - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= (headPtr == queuePtrWidth'(queueSize - 1)) ? '0 : headPtr + 1'b1;
            end
            if (push && !pop) begin
                queueCount <= queueCount + 1'b1;
            end else if (pop && !push) begin
                queueCount <= queueCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            queue[tailPtr] <= '{index: updIndex[pushLane], counter: updCounter[pushLane]};
        end
    end

    PredictorRam #(
        .entryType(PhtCounter),
        .entryNum(phtEntryNum),
        .readNum(fetchWidth)
    ) u_PhtRam (
        .clock(clock),
        .writeEnable(writeEnable),
        .writeAddr(writeIndex),
        .writeData(writeCounter),
        .readAddr(readIndex),
        .readData(counterRead)
    );

endmodule

// ==== logic/PredictorRam.sv ====
/*
 * Predictor table storage.
 * One write port and readNum registered read ports over an array
 * of entryType; a read in the cycle of a write sees the old value.
 */
module PredictorRam #(
    parameter type entryType = logic,
    parameter int entryNum = 16,
    parameter int readNum = 2
) (
    input  logic clock,
    input  logic writeEnable,
    input  logic [$clog2(entryNum)-1:0] writeAddr,
    input  entryType writeData,
    input  logic [$clog2(entryNum)-1:0] readAddr [readNum],
    output entryType readData [readNum]
);

    entryType storage [entryNum];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            storage[writeAddr] <= writeData;
        end
    end

    // Registered reads, one per port.
    always_ff @(posedge clock) begin
        for (int port = 0; port < readNum; port++) begin
            readData[port] <= storage[readAddr[port]];
        end
    end

endmodule

// ==== logic/PredictorTypes.sv ====
/*
 * Predictor table types.
 * Direction counters, BTB entries and the record kept in the
 * PHT update queue.
 */
package PredictorTypes;

    // Saturating direction counter whose top bit means taken.
    localparam int counterBitWidth = 2;
    typedef logic [counterBitWidth-1:0] PhtCounter;

    localparam PhtCounter counterMax = 2'd3;

    // Weakly taken.
    localparam PhtCounter counterInit = 2'd2;

    localparam int btbTagBitWidth = 20;
    typedef logic [btbTagBitWidth-1:0] BtbTag;

    typedef struct packed {
        logic valid;
        BtbTag tag;
        AddressTypes::WordAddr target;
    } BtbEntry;

    localparam int phtIndexBitWidth = 8;
    typedef logic [phtIndexBitWidth-1:0] PhtIndex;

    // A counter write waiting for the PHT write port.
    typedef struct packed {
        PhtIndex index;
        PhtCounter counter;
    } PhtUpdate;

endpackage

// ==== logic/AddressTypes.sv ====
/*
 * Instruction address types.
 * Byte and word addresses, and the geometry of a fetch group, shared
 * by the predictor tables and the combiner.
 */
package AddressTypes;

    localparam int pcBitWidth = 32;
    localparam int insnByteWidth = 4;

    // Low address bits below one instruction.
    localparam int insnAddrBitWidth = $clog2(insnByteWidth);

    typedef logic [pcBitWidth-1:0] PcAddr;

    // An instruction address with its byte offset stripped.
    typedef logic [pcBitWidth-insnAddrBitWidth-1:0] WordAddr;

    // Address of the given slot within the fetch group starting at groupPc.
    function automatic PcAddr slotAddr(PcAddr groupPc, int slot);
        return groupPc + PcAddr'(slot * insnByteWidth);
    endfunction

    function automatic WordAddr toWordAddr(PcAddr pc);
        return pc[pcBitWidth-1:insnAddrBitWidth];
    endfunction

    function automatic PcAddr toPcAddr(WordAddr word);
        return {word, {insnAddrBitWidth{1'b0}}};
    endfunction

endpackage
